// ==== wb_pkg.sv ====
package wb_pkg;

    ////////////////////////////////////////////////////////////
    // fabric sizing
    ////////////////////////////////////////////////////////////

    // user-project banks behind the 0x30 region
    localparam int NUM_TEAMS = 6;
    // sram + gpio + one slot per team
    localparam int NUM_SLOTS = NUM_TEAMS + 2;
    localparam int SLOT_W    = $clog2(NUM_SLOTS);

    // fixed slot indices, team t sits at SLOT_TEAM0 + t
    localparam int SLOT_SRAM  = 0;
    localparam int SLOT_GPIO  = 1;
    localparam int SLOT_TEAM0 = 2;

    localparam int SRAM_WORDS   = 256;
    localparam int SRAM_AW      = $clog2(SRAM_WORDS);
    localparam int TEAM_SCRATCH = 4;
    localparam int TEAM_SCR_AW  = $clog2(TEAM_SCRATCH);

    ////////////////////////////////////////////////////////////
    // address map
    ////////////////////////////////////////////////////////////

    // top byte of the address picks the region
    localparam logic [7:0] PFX_USER = 8'h30;
    localparam logic [7:0] PFX_GPIO = 8'h32;
    localparam logic [7:0] PFX_SRAM = 8'h33;

    // register offsets inside a region
    localparam logic [15:0] GPIO_OUT    = 16'h0000;
    localparam logic [15:0] GPIO_OE     = 16'h0004;
    localparam logic [15:0] GPIO_IN     = 16'h0008;
    localparam logic [15:0] TEAM_ID_OFS = 16'h0010;

    typedef logic [SLOT_W-1:0] slot_idx_t;

    // gpio and sram regions
    typedef struct packed {
        logic [7:0]  prefix;
        logic [23:0] offset;
    } wb_fixed_adr_t;

    // user-project region, bits 19:16 pick the team
    typedef struct packed {
        logic [7:0]  prefix;
        logic [3:0]  rsvd;
        logic [3:0]  team;
        logic [15:0] offset;
    } wb_user_adr_t;

    // one address word, two readings
    typedef union packed {
        wb_fixed_adr_t fixed;
        wb_user_adr_t  user;
    } wb_addr_u;

    ////////////////////////////////////////////////////////////
    // bus bundles
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        wb_addr_u    adr;
        logic [31:0] dat;
        logic [3:0]  sel;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic        err;
        logic [31:0] dat;
    } wb_rsp_t;

    typedef wb_req_t [NUM_SLOTS-1:0] slot_req_t;
    typedef wb_rsp_t [NUM_SLOTS-1:0] slot_rsp_t;

    // byte-lane merge for register writes
    function automatic logic [31:0] wb_merge(
        input logic [31:0] old_word,
        input logic [31:0] new_word,
        input logic [3:0]  sel
    );
        logic [31:0] merged;
        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

endpackage

// ==== wb_sram.sv ====
module wb_sram import wb_pkg::*; (
    input  logic    CLK,
    input  logic    nRST,
    input  wb_req_t req,
    output wb_rsp_t rsp
);

    logic [31:0] mem [SRAM_WORDS];

    logic [SRAM_AW-1:0] word_idx;
    logic               access;
    logic               ack_q;
    logic [31:0]        rdata_q;

    // word index, upper offset bits alias
    assign word_idx = req.adr.fixed.offset[SRAM_AW+1:2];

    // one access per request, held stb after ack is not served twice
    assign access = req.cyc && req.stb && !ack_q;

    ////////////////////////////////////////////////////////////
    // ack pulse
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    ////////////////////////////////////////////////////////////
    // array
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (access) begin
            // byte lanes written only where sel is set
            if (req.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (req.sel[b]) begin
                        mem[word_idx][8*b +: 8] <= req.dat[8*b +: 8];
                    end
                end
            end
            // read returns the word before this write
            rdata_q <= mem[word_idx];
        end
    end

    assign rsp = '{ack: ack_q, err: 1'b0, dat: rdata_q};

endmodule

// ==== wb_gpio.sv ====
module wb_gpio import wb_pkg::*; (
    input  logic        CLK,
    input  logic        nRST,
    input  wb_req_t     req,
    output wb_rsp_t     rsp,
    input  logic [31:0] gpio_in,
    output logic [31:0] gpio_out,
    output logic [31:0] gpio_oe
);

    logic [31:0] out_q;
    logic [31:0] oe_q;
    // two-flop input synchronizer
    logic [31:0] in_meta;
    logic [31:0] in_sync;

    logic [15:0] word_ofs;
    logic        access;
    logic        ack_q;
    logic [31:0] rdata_d;
    logic [31:0] rdata_q;

    // byte bits within the word are ignored
    assign word_ofs = {req.adr.fixed.offset[15:2], 2'b00};
    assign access   = req.cyc && req.stb && !ack_q;

    always_comb begin
        case (word_ofs)
            GPIO_OUT: rdata_d = out_q;
            GPIO_OE:  rdata_d = oe_q;
            GPIO_IN:  rdata_d = in_sync;
            default:  rdata_d = '0;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            out_q   <= '0;
            oe_q    <= '0;
            in_meta <= '0;
            in_sync <= '0;
            ack_q   <= 1'b0;
        end else begin
            in_meta <= gpio_in;
            in_sync <= in_meta;
            ack_q   <= access;
            // in is read-only, unknown offsets drop the write
            if (access && req.we) begin
                if (word_ofs == GPIO_OUT) begin
                    out_q <= wb_merge(out_q, req.dat, req.sel);
                end
                if (word_ofs == GPIO_OE) begin
                    oe_q <= wb_merge(oe_q, req.dat, req.sel);
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (access) begin
            rdata_q <= rdata_d;
        end
    end

    assign rsp      = '{ack: ack_q, err: 1'b0, dat: rdata_q};
    assign gpio_out = out_q;
    assign gpio_oe  = oe_q;

endmodule

// ==== wb_team_regs.sv ====
module wb_team_regs import wb_pkg::*; #(
    parameter int TEAM_ID = 0
) (
    input  logic    CLK,
    input  logic    nRST,
    input  wb_req_t req,
    output wb_rsp_t rsp
);

    logic [31:0] scratch [TEAM_SCRATCH];

    logic [15:0]            ofs;
    logic                   scr_hit;
    logic [TEAM_SCR_AW-1:0] scr_idx;
    logic                   access;
    logic                   ack_q;
    logic [31:0]            rdata_q;

    assign ofs     = req.adr.user.offset;
    // scratch words sit at the bottom of the bank
    assign scr_hit = (ofs[15:TEAM_SCR_AW+2] == '0);
    assign scr_idx = ofs[TEAM_SCR_AW+1:2];
    assign access  = req.cyc && req.stb && !ack_q;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ack_q <= 1'b0;
            for (int i = 0; i < TEAM_SCRATCH; i++) begin
                scratch[i] <= '0;
            end
        end else begin
            ack_q <= access;
            if (access && req.we && scr_hit) begin
                scratch[scr_idx] <= wb_merge(scratch[scr_idx], req.dat, req.sel);
            end
        end
    end

    // identity word is read-only
    always_ff @(posedge CLK) begin
        if (access) begin
            if (scr_hit) begin
                rdata_q <= scratch[scr_idx];
            end else if ({ofs[15:2], 2'b00} == TEAM_ID_OFS) begin
                rdata_q <= 32'(TEAM_ID);
            end else begin
                rdata_q <= '0;
            end
        end
    end

    assign rsp = '{ack: ack_q, err: 1'b0, dat: rdata_q};

endmodule

// ==== wb_arbiter.sv ====
module wb_arbiter import wb_pkg::*; (
    input  logic    CLK,
    input  logic    nRST,

    // manager side
    input  wb_req_t m0_req,
    input  wb_req_t m1_req,
    output wb_rsp_t m0_rsp,
    output wb_rsp_t m1_rsp,

    // toward the decoder
    output wb_req_t bus_req,
    input  wb_rsp_t bus_rsp
);

    // 0 picks m0, 1 picks m1
    logic grant_q;
    logic grant_d;
    // manager that got the most recent ack or err
    logic last_q;

    wb_req_t own_req;
    wb_req_t other_req;

    ////////////////////////////////////////////////////////////
    // grant selection
    ////////////////////////////////////////////////////////////

    assign own_req   = grant_q ? m1_req : m0_req;
    assign other_req = grant_q ? m0_req : m1_req;

    always_comb begin
        grant_d = grant_q;
        // granted manager still in its cycle, keep it
        if (!own_req.cyc) begin
            if (other_req.cyc) begin
                grant_d = ~grant_q;
            end else begin
                // nobody waiting, park on whoever was not served last
                grant_d = ~last_q;
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            grant_q <= 1'b0;
            // so the park position after reset is m0
            last_q  <= 1'b1;
        end else begin
            grant_q <= grant_d;
            if (bus_rsp.ack || bus_rsp.err) begin
                last_q <= grant_q;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // request forward and response steering
    ////////////////////////////////////////////////////////////

    assign bus_req = own_req;

    // idle manager sees an all-zero response
    assign m0_rsp = grant_q ? '0 : bus_rsp;
    assign m1_rsp = grant_q ? bus_rsp : '0;

endmodule

// ==== wb_decoder.sv ====
module wb_decoder import wb_pkg::*; (
    input  logic      CLK,
    input  logic      nRST,

    // granted manager
    input  wb_req_t   bus_req,
    output wb_rsp_t   bus_rsp,

    // peripheral slots
    output slot_req_t slot_req,
    input  slot_rsp_t slot_rsp
);

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        DONE
    } state_t;

    state_t    state_q;

    // decode of the live bus address
    logic      dec_hit;
    slot_idx_t dec_slot;

    // captured request and its target
    wb_req_t   req_q;
    slot_idx_t slot_q;

    // manager-facing response registers
    logic        ack_q;
    logic        err_q;
    logic [31:0] dat_q;

    wb_rsp_t sel_rsp;
    logic    accept;

    ////////////////////////////////////////////////////////////
    // address decode
    ////////////////////////////////////////////////////////////

    always_comb begin
        dec_hit  = 1'b0;
        dec_slot = '0;
        case (bus_req.adr.fixed.prefix)
            PFX_USER: begin
                // only teams that exist
                if (bus_req.adr.user.team < NUM_TEAMS) begin
                    dec_hit  = 1'b1;
                    dec_slot = slot_idx_t'(SLOT_TEAM0 + int'(bus_req.adr.user.team));
                end
            end
            PFX_GPIO: begin
                if (bus_req.adr.fixed.offset[23:16] == 8'h00) begin
                    dec_hit  = 1'b1;
                    dec_slot = slot_idx_t'(SLOT_GPIO);
                end
            end
            PFX_SRAM: begin
                if (bus_req.adr.fixed.offset[23:16] == 8'h00) begin
                    dec_hit  = 1'b1;
                    dec_slot = slot_idx_t'(SLOT_SRAM);
                end
            end
            // la region and anything else falls to err
            default: begin
                dec_hit = 1'b0;
            end
        endcase
    end

    assign accept  = (state_q == IDLE) && bus_req.cyc && bus_req.stb;
    assign sel_rsp = slot_rsp[slot_q];

    ////////////////////////////////////////////////////////////
    // transfer FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state_q <= IDLE;
            ack_q   <= 1'b0;
            err_q   <= 1'b0;
            dat_q   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (accept) begin
                        if (dec_hit) begin
                            state_q <= ACCESS;
                        end else begin
                            // unmapped, err shows up next cycle
                            err_q   <= 1'b1;
                            state_q <= DONE;
                        end
                    end
                end
                ACCESS: begin
                    // slot answered, stb drops on this same edge
                    if (sel_rsp.ack || sel_rsp.err) begin
                        ack_q   <= sel_rsp.ack;
                        err_q   <= sel_rsp.err;
                        dat_q   <= sel_rsp.dat;
                        state_q <= DONE;
                    end
                end
                DONE: begin
                    // single pulse, stb ignored here
                    ack_q   <= 1'b0;
                    err_q   <= 1'b0;
                    dat_q   <= '0;
                    state_q <= IDLE;
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // request held for the whole access
    always_ff @(posedge CLK) begin
        if (accept) begin
            req_q  <= bus_req;
            slot_q <= dec_slot;
        end
    end

    ////////////////////////////////////////////////////////////
    // slot routing
    ////////////////////////////////////////////////////////////

    always_comb begin
        // unselected slots see all zeros
        slot_req = '0;
        if (state_q == ACCESS) begin
            slot_req[slot_q] = req_q;
        end
    end

    assign bus_rsp = '{ack: ack_q, err: err_q, dat: dat_q};

endmodule

// ==== wb_fabric_top.sv ====
module wb_fabric_top import wb_pkg::*; (
    input  logic        CLK,
    input  logic        nRST,

    // two bus managers
    input  wb_req_t     m0_req,
    input  wb_req_t     m1_req,
    output wb_rsp_t     m0_rsp,
    output wb_rsp_t     m1_rsp,

    // gpio pins
    input  logic [31:0] gpio_in,
    output logic [31:0] gpio_out,
    output logic [31:0] gpio_oe
);

    // arbiter to decoder
    wb_req_t   bus_req;
    wb_rsp_t   bus_rsp;

    // decoder to peripherals
    slot_req_t slot_req;
    slot_rsp_t slot_rsp;

    ////////////////////////////////////////////////////////////
    // producer and buffer
    ////////////////////////////////////////////////////////////

    wb_arbiter u_arbiter (
        .CLK     (CLK),
        .nRST    (nRST),
        .m0_req  (m0_req),
        .m1_req  (m1_req),
        .m0_rsp  (m0_rsp),
        .m1_rsp  (m1_rsp),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp)
    );

    wb_decoder u_decoder (
        .CLK      (CLK),
        .nRST     (nRST),
        .bus_req  (bus_req),
        .bus_rsp  (bus_rsp),
        .slot_req (slot_req),
        .slot_rsp (slot_rsp)
    );

    ////////////////////////////////////////////////////////////
    // peripherals
    ////////////////////////////////////////////////////////////

    wb_sram u_sram (
        .CLK  (CLK),
        .nRST (nRST),
        .req  (slot_req[SLOT_SRAM]),
        .rsp  (slot_rsp[SLOT_SRAM])
    );

    wb_gpio u_gpio (
        .CLK      (CLK),
        .nRST     (nRST),
        .req      (slot_req[SLOT_GPIO]),
        .rsp      (slot_rsp[SLOT_GPIO]),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out),
        .gpio_oe  (gpio_oe)
    );

    // one bank per team, identity is its team index
    for (genvar t = 0; t < NUM_TEAMS; t++) begin : g_team
        wb_team_regs #(
            .TEAM_ID (t)
        ) u_team (
            .CLK  (CLK),
            .nRST (nRST),
            .req  (slot_req[SLOT_TEAM0 + t]),
            .rsp  (slot_rsp[SLOT_TEAM0 + t])
        );
    end

endmodule

// ==== tb_wb_fabric.sv ====
module tb_wb_fabric import wb_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    // cycles a manager waits for ack or err
    localparam int WAIT_LIMIT = 40;
    localparam int XFERS      = 150;
    localparam int ROUNDS     = 3;

    logic        CLK;
    logic        nRST;
    wb_req_t     mreq [2];
    wb_rsp_t     mrsp [2];
    logic [31:0] gpio_in;
    logic [31:0] gpio_out;
    logic [31:0] gpio_oe;

    // reference model of every slot
    logic [31:0] sram_m [SRAM_WORDS];
    logic [31:0] out_m;
    logic [31:0] oe_m;
    logic [31:0] team_m [NUM_TEAMS][TEAM_SCRATCH];

    wb_fabric_top dut (
        .CLK      (CLK),
        .nRST     (nRST),
        .m0_req   (mreq[0]),
        .m1_req   (mreq[1]),
        .m0_rsp   (mrsp[0]),
        .m1_rsp   (mrsp[1]),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out),
        .gpio_oe  (gpio_oe)
    );

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    ////////////////////////////////////////////////////////////
    // checking helpers
    ////////////////////////////////////////////////////////////

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at first failure");
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            fail_now($sformatf("Error: %s = 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    // sel picks which bytes of the write land
    function automatic logic [31:0] merge_bytes(
        input logic [31:0] cur,
        input logic [31:0] wdat,
        input logic [3:0]  sel
    );
        logic [31:0] mask;
        mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
        return (cur & ~mask) | (wdat & mask);
    endfunction

    // initial sram contents depend on every address bit
    function automatic logic [31:0] fill_word(input int idx);
        return (32'(idx) * 32'h9e3779b1) ^ {4{8'(idx)}} ^ 32'h5a00_00c3;
    endfunction

    task automatic check_pins();
        check_val("gpio_out", gpio_out, out_m);
        check_val("gpio_oe", gpio_oe, oe_m);
    endtask

    ////////////////////////////////////////////////////////////
    // one classic wishbone transfer
    ////////////////////////////////////////////////////////////

    task automatic transfer(
        input int          m,
        input logic        we,
        input logic [31:0] adr,
        input logic [31:0] dat,
        input logic [3:0]  sel,
        input logic        exp_err,
        input logic [31:0] exp_rd
    );
        wb_req_t r;
        wb_rsp_t rsp;
        wb_rsp_t oth;
        int      waited;
        string   who;
        who = $sformatf("m%0d_rsp", m);
        r = '0;
        r.cyc = 1'b1;
        r.stb = 1'b1;
        r.we  = we;
        r.adr = adr;
        r.dat = dat;
        r.sel = sel;
        mreq[m] = r;
        rsp = '0;
        waited = 0;
        // request held until ack or err
        while (!rsp.ack && !rsp.err) begin
            @(negedge CLK);
            rsp = mrsp[m];
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_now($sformatf("manager %0d saw no ack or err within %0d cycles",
                                   m, WAIT_LIMIT));
            end
            if (!rsp.ack && !rsp.err) begin
                check_val({who, ".dat"}, rsp.dat, 32'd0);
            end
        end
        // other manager is not granted and reads all zero
        oth = mrsp[1-m];
        check_val($sformatf("m%0d_rsp.ack_err", 1-m), {30'd0, oth.ack, oth.err}, 32'd0);
        check_val($sformatf("m%0d_rsp.dat", 1-m), oth.dat, 32'd0);
        check_val({who, ".ack"}, {31'd0, rsp.ack}, {31'd0, ~exp_err});
        check_val({who, ".err"}, {31'd0, rsp.err}, {31'd0, exp_err});
        if (!we && !exp_err) begin
            check_val({who, ".dat"}, rsp.dat, exp_rd);
        end
        mreq[m] = '0;
        // pulse lasts one cycle only
        @(negedge CLK);
        rsp = mrsp[m];
        check_val({who, ".ack_err"}, {30'd0, rsp.ack, rsp.err}, 32'd0);
    endtask

    ////////////////////////////////////////////////////////////
    // per-slot operations
    ////////////////////////////////////////////////////////////

    // manager m owns the sram words whose index parity is m
    task automatic sram_op(input int m, input logic we, input logic [31:0] dat,
                           input logic [3:0] sel);
        int          idx;
        logic [31:0] adr;
        idx = (int'($urandom_range(127, 0)) << 1) | m;
        adr = {PFX_SRAM, 8'h00, 6'($urandom_range(63, 0)), 8'(idx), 2'b00};
        transfer(m, we, adr, dat, sel, 1'b0, sram_m[idx]);
        if (we) begin
            sram_m[idx] = merge_bytes(sram_m[idx], dat, sel);
            // read back through another alias
            adr = {PFX_SRAM, 8'h00, 6'($urandom_range(63, 0)), 8'(idx), 2'b00};
            transfer(m, 1'b0, adr, 32'd0, 4'h0, 1'b0, sram_m[idx]);
        end
    endtask

    // m0 owns OUT and m1 owns OE
    task automatic gpio_op(input int m, input logic we, input logic [31:0] dat,
                           input logic [3:0] sel);
        int          kind;
        logic [15:0] ofs;
        logic [31:0] exp;
        logic [31:0] adr;
        kind = int'($urandom_range(2, 0));
        case (kind)
            0: begin
                ofs = (m == 0) ? GPIO_OUT : GPIO_OE;
                exp = (m == 0) ? out_m : oe_m;
            end
            1: begin
                ofs = GPIO_IN;
                exp = gpio_in;
            end
            default: begin
                // unused offsets read zero
                ofs = 16'(12 + 4 * int'($urandom_range(16380, 0)));
                exp = 32'd0;
            end
        endcase
        adr = {PFX_GPIO, 8'h00, ofs};
        transfer(m, we, adr, dat, sel, 1'b0, exp);
        if (we) begin
            if (kind == 0 && m == 0) begin
                out_m = merge_bytes(out_m, dat, sel);
                exp   = out_m;
            end else if (kind == 0) begin
                oe_m = merge_bytes(oe_m, dat, sel);
                exp  = oe_m;
            end
            check_pins();
            transfer(m, 1'b0, adr, 32'd0, 4'h0, 1'b0, exp);
        end
    endtask

    // scratch words m and m+2 belong to manager m
    task automatic team_op(input int m, input logic we, input logic [31:0] dat,
                           input logic [3:0] sel);
        int          t;
        int          w;
        int          kind;
        logic [15:0] ofs;
        logic [31:0] exp;
        logic [31:0] adr;
        t    = int'($urandom_range(NUM_TEAMS - 1, 0));
        w    = (int'($urandom_range(1, 0)) << 1) | m;
        kind = int'($urandom_range(2, 0));
        case (kind)
            0: begin
                ofs = 16'(4 * w);
                exp = team_m[t][w];
            end
            1: begin
                // identity word is never written
                ofs = TEAM_ID_OFS;
                exp = 32'(t);
            end
            default: begin
                ofs = 16'(20 + 4 * int'($urandom_range(16378, 0)));
                exp = 32'd0;
            end
        endcase
        // bits 23:20 do not take part in the team decode
        adr = {PFX_USER, 4'($urandom_range(15, 0)), 4'(t), ofs};
        transfer(m, we, adr, dat, sel, 1'b0, exp);
        if (we) begin
            if (kind == 0) begin
                team_m[t][w] = merge_bytes(team_m[t][w], dat, sel);
                exp = team_m[t][w];
            end
            transfer(m, 1'b0, adr, 32'd0, 4'h0, 1'b0, exp);
        end
    endtask

    // addresses that must end in err and change nothing
    task automatic bad_op(input int m, input logic we, input logic [31:0] dat,
                          input logic [3:0] sel);
        int          kind;
        logic [7:0]  pfx;
        logic [31:0] adr;
        kind = int'($urandom_range(3, 0));
        case (kind)
            0: begin
                adr = {PFX_USER, 4'($urandom_range(15, 0)),
                       4'($urandom_range(15, NUM_TEAMS)), 16'($urandom)};
            end
            1: begin
                // logic analyzer region is not mapped
                adr = {8'h31, 24'($urandom)};
            end
            2: begin
                pfx = 8'($urandom_range(255, 0));
                if (pfx inside {PFX_USER, PFX_GPIO, PFX_SRAM}) begin
                    pfx = 8'ha5;
                end
                adr = {pfx, 24'($urandom)};
            end
            default: begin
                pfx = ($urandom_range(1, 0) == 1) ? PFX_GPIO : PFX_SRAM;
                adr = {pfx, 8'($urandom_range(255, 1)), 16'($urandom)};
            end
        endcase
        transfer(m, we, adr, dat, sel, 1'b1, 32'd0);
        check_pins();
    endtask

    task automatic run_manager(input int m, input int n);
        int          cls;
        logic        we;
        logic [31:0] dat;
        logic [3:0]  sel;
        for (int i = 0; i < n; i++) begin
            cls = int'($urandom_range(3, 0));
            we  = 1'($urandom_range(1, 0));
            dat = $urandom;
            sel = 4'($urandom_range(15, 0));
            case (cls)
                0: sram_op(m, we, dat, sel);
                1: gpio_op(m, we, dat, sel);
                2: team_op(m, we, dat, sel);
                default: bad_op(m, we, dat, sel);
            endcase
            // uneven gaps so both grant orders show up
            repeat ($urandom_range(2, 0)) @(negedge CLK);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(32'h404832f2));
        nRST     = 1'b0;
        mreq[0]  = '0;
        mreq[1]  = '0;
        gpio_in  = '0;
        out_m    = '0;
        oe_m     = '0;
        for (int t = 0; t < NUM_TEAMS; t++) begin
            for (int w = 0; w < TEAM_SCRATCH; w++) begin
                team_m[t][w] = '0;
            end
        end
        repeat (4) @(negedge CLK);
        nRST = 1'b1;
        @(negedge CLK);
        // reset state
        check_val("m0_rsp.ack_err", {30'd0, mrsp[0].ack, mrsp[0].err}, 32'd0);
        check_val("m1_rsp.ack_err", {30'd0, mrsp[1].ack, mrsp[1].err}, 32'd0);
        check_pins();
        // known sram contents before random traffic
        for (int i = 0; i < SRAM_WORDS; i++) begin
            transfer(0, 1'b1, {PFX_SRAM, 14'd0, 8'(i), 2'b00}, fill_word(i), 4'hf, 1'b0, 32'd0);
            sram_m[i] = fill_word(i);
        end
        for (int r = 0; r < ROUNDS; r++) begin
            // new pin value held steady before any read
            gpio_in = $urandom;
            repeat (4) @(negedge CLK);
            fork
                run_manager(0, XFERS);
                run_manager(1, XFERS);
            join
        end
        check_pins();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== wb_fabric.f ====
wb_pkg.sv
wb_sram.sv
wb_gpio.sv
wb_team_regs.sv
wb_arbiter.sv
wb_decoder.sv
wb_fabric_top.sv
tb_wb_fabric.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the fabric testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 \
    --top-module tb_wb_fabric \
    -f wb_fabric.f
./obj_dir/Vtb_wb_fabric
